//--- tb.f
verilog/icache_pkg.sv
verilog/refill_counter.sv
verilog/icache_tagv.sv
verilog/icache_data.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
verif/mem_model.sv
verif/tb_icache.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f tb.f --top-module tb_icache -o sim_icache
./obj_dir/sim_icache | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- verif/tb_icache.sv
module tb_icache import icache_pkg::*; ();

    typedef struct packed {
        op_t         op;
        logic [31:0] addr;
        logic        unc;
        logic        hit;
        logic        err;
        logic        done;
    } entry_t;

    logic        clk;
    logic        rstn;
    logic        req_valid;
    req_t        req;
    logic        req_ready;
    logic        resp_valid;
    resp_t       resp;
    logic        mem_req_valid;
    mem_req_t    mem_req;
    logic        beat_valid;
    logic [31:0] rdata;
    int          bursts;

    entry_t      table_q [$];
    int          val_errs;
    int          burst_errs;
    int          cycles;
    int          limit;

    icache_top dut_i (
        .clk              (clk),
        .rstn             (rstn),
        .i_req_valid      (req_valid),
        .i_req            (req),
        .i_mem_beat_valid (beat_valid),
        .i_mem_rdata      (rdata),
        .o_req_ready      (req_ready),
        .o_resp_valid     (resp_valid),
        .o_resp           (resp),
        .o_mem_req_valid  (mem_req_valid),
        .o_mem_req        (mem_req)
    );

    mem_model mem_i (
        .clk          (clk),
        .rstn         (rstn),
        .i_req_valid  (mem_req_valid),
        .i_req        (mem_req),
        .o_beat_valid (beat_valid),
        .o_rdata      (rdata),
        .o_bursts     (bursts)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic add_entry(input op_t op, input logic [31:0] addr, input logic [3:0] flags);
        entry_t e;
        e.op   = op;
        e.addr = addr;
        {e.unc, e.hit, e.err, e.done} = flags;
        table_q.push_back(e);
    endtask

    task automatic check_resp(input resp_t got, input resp_t exp_resp, input logic data_on);
        if (got.addr_err !== exp_resp.addr_err || got.cacop_done !== exp_resp.cacop_done ||
            got.hit !== exp_resp.hit || got.uncached !== exp_resp.uncached ||
            (data_on && got.data !== exp_resp.data)) begin
            val_errs++;
            $display("error at %0t: resp data %h err %b done %b hit %b unc %b", $time,
                     got.data, got.addr_err, got.cacop_done, got.hit, got.uncached);
            $display("  expected data %h err %b done %b hit %b unc %b (data %s)",
                     exp_resp.data, exp_resp.addr_err, exp_resp.cacop_done, exp_resp.hit,
                     exp_resp.uncached, data_on ? "checked" : "ignored");
        end
    endtask

    task automatic check_mem_req(input mem_req_t got, input mem_req_t exp_req);
        if (got !== exp_req) begin
            val_errs++;
            $display("error at %0t: mem req addr %h beats %0d, expected addr %h beats %0d",
                     $time, got.addr, got.beats, exp_req.addr, exp_req.beats);
        end
    endtask

    task automatic compare_bursts(input int got, input int want, input logic [31:0] addr);
        if (got != want) begin
            burst_errs++;
            $display("error at %0t: %0d bursts for address %h, expected %0d",
                     $time, got, addr, want);
        end
    endtask

    // one request, then wait for its response pulse
    task automatic issue_entry(input entry_t e);
        resp_t    exp_resp;
        mem_req_t exp_req;
        logic     data_on;
        logic     want_burst;
        logic     seen;
        int       b0;
        data_on             = (e.op == OP_FETCH) && !e.err;
        want_burst          = data_on && (e.unc || !e.hit);
        exp_resp.data       = {e.addr[31:2], 2'b00} ^ 32'h5a5a0000;
        exp_resp.addr_err   = e.err;
        exp_resp.cacop_done = e.done;
        exp_resp.hit        = e.hit;
        exp_resp.uncached   = data_on && e.unc;
        exp_req.addr        = e.unc ? {e.addr[31:2], 2'b00} : {e.addr[31:4], 4'h0};
        exp_req.beats       = e.unc ? 3'(BURST_UNCACHED) : 3'(BURST_LINE);
        seen = 1'b0;
        b0   = bursts;
        while (!req_ready) begin
            @(posedge clk);
            #2;
        end
        req_valid    = 1'b1;
        req.op       = e.op;
        req.addr     = e.addr;
        req.uncached = e.unc;
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        while (!resp_valid) begin
            if (mem_req_valid && !seen) begin   // burst start
                seen = 1'b1;
                check_mem_req(mem_req, exp_req);
            end
            @(posedge clk);
            #2;
        end
        check_resp(resp, exp_resp, data_on);
        compare_bursts(bursts - b0, int'(want_burst), e.addr);
    endtask

    initial begin
        rstn       = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        val_errs   = 0;
        burst_errs = 0;
        // op, address, {uncached, hit, addr_err, cacop_done}
        add_entry(OP_FETCH,   32'h0000_1034, 4'b0000);   // line A cold miss
        add_entry(OP_FETCH,   32'h0000_103c, 4'b0100);
        add_entry(OP_FETCH,   32'h0000_1030, 4'b0100);
        add_entry(OP_FETCH,   32'h0000_2038, 4'b0000);   // line B, same set
        add_entry(OP_FETCH,   32'h0000_1034, 4'b0100);
        add_entry(OP_FETCH,   32'h0000_3030, 4'b0000);   // C evicts B
        add_entry(OP_FETCH,   32'h0000_1038, 4'b0100);
        add_entry(OP_FETCH,   32'h0000_2038, 4'b0000);
        add_entry(OP_FETCH,   32'h0000_5074, 4'b1000);   // uncached
        add_entry(OP_FETCH,   32'h0000_5074, 4'b0000);
        add_entry(OP_FETCH,   32'h0000_5076, 4'b0010);
        add_entry(OP_FETCH,   32'h0000_1031, 4'b0010);
        add_entry(OP_IDX_INV, 32'h0000_0030, 4'b0001);   // set 3 way 0
        add_entry(OP_FETCH,   32'h0000_1034, 4'b0000);
        add_entry(OP_FETCH,   32'h0000_2030, 4'b0100);
        add_entry(OP_HIT_INV, 32'h0000_2034, 4'b0001);
        add_entry(OP_FETCH,   32'h0000_2034, 4'b0000);
        add_entry(OP_FETCH,   32'h0000_203c, 4'b0100);
        add_entry(OP_HIT_INV, 32'h0000_9030, 4'b0001);   // no match
        add_entry(OP_IDX_INV, 32'h0000_0071, 4'b0001);   // set 7 way 1, empty
        add_entry(OP_FETCH,   32'h0000_5078, 4'b0100);
        add_entry(OP_FETCH,   32'h0000_3030, 4'b0000);
        add_entry(OP_FETCH,   32'h0000_2030, 4'b0100);
        repeat (2) @(posedge clk);
        #2;
        rstn = 1'b1;
        if (!req_ready || resp_valid || mem_req_valid) begin
            val_errs++;
            $display("error at %0t: ports not idle after reset", $time);
        end
        foreach (table_q[i])
            issue_entry(table_q[i]);
        @(posedge clk);
        $display("errors: %0d value, %0d burst count", val_errs, burst_errs);
        if (val_errs == 0 && burst_errs == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    // run limit scales with the table
    initial begin
        cycles = 0;
        @(posedge rstn);
        limit = table_q.size() * 40;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- verif/mem_model.sv
module mem_model import icache_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        i_req_valid,
    input  mem_req_t    i_req,
    output logic        o_beat_valid,
    output logic [31:0] o_rdata,
    output int          o_bursts
);

    int          seed;
    int          delay;
    logic [31:0] base;
    logic [2:0]  beats;

    // word data is its own byte address xor a fixed pattern
    initial begin
        seed         = 70758;
        o_beat_valid = 1'b0;
        o_rdata      = '0;
        o_bursts     = 0;
        forever begin
            @(posedge clk);
            #2;
            if (rstn && i_req_valid) begin
                base     = i_req.addr;   // latched on first sight of the request
                beats    = i_req.beats;
                o_bursts = o_bursts + 1;
                for (int k = 0; k < int'(beats); k++) begin
                    delay        = $unsigned($random(seed)) % 4;   // 0 to 3 idle cycles
                    o_beat_valid = 1'b0;
                    repeat (delay) begin
                        @(posedge clk);
                        #2;
                    end
                    o_beat_valid = 1'b1;
                    o_rdata      = (base + 32'(4 * k)) ^ 32'h5a5a0000;
                    @(posedge clk);
                    #2;
                end
                o_beat_valid = 1'b0;
            end
        end
    end

endmodule

//--- verilog/icache_top.sv
module icache_top import icache_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        i_req_valid,
    input  req_t        i_req,
    input  logic        i_mem_beat_valid,
    input  logic [31:0] i_mem_rdata,
    output logic        o_req_ready,
    output logic        o_resp_valid,
    output resp_t       o_resp,
    output logic        o_mem_req_valid,
    output mem_req_t    o_mem_req
);

    logic                  hit, hit_way, victim_way;
    logic                  burst_done;
    logic [WORD_OFF_W-1:0] slot;
    logic                  lookup_en, refill_start;
    logic                  fill_we, fill_way;
    logic                  inval_we, inval_way;
    logic                  lru_update, lru_way;
    logic                  from_buf, addr_err;
    req_t                  req_buf;
    logic [31:0]           word;
    logic                  is_fetch;

    icache_ctrl ctrl_i (
        .clk              (clk),
        .rstn             (rstn),
        .i_req_valid      (i_req_valid),
        .i_req            (i_req),
        .i_hit            (hit),
        .i_hit_way        (hit_way),
        .i_victim_way     (victim_way),
        .i_burst_done     (burst_done),
        .i_mem_beat_valid (i_mem_beat_valid),
        .o_req_ready      (o_req_ready),
        .o_resp_valid     (o_resp_valid),
        .o_lookup_en      (lookup_en),
        .o_refill_start   (refill_start),
        .o_mem_req_valid  (o_mem_req_valid),
        .o_mem_req        (o_mem_req),
        .o_fill_we        (fill_we),
        .o_fill_way       (fill_way),
        .o_inval_we       (inval_we),
        .o_inval_way      (inval_way),
        .o_lru_update     (lru_update),
        .o_lru_way        (lru_way),
        .o_from_buf       (from_buf),
        .o_req_buf        (req_buf),
        .o_addr_err       (addr_err)
    );

    refill_counter cnt_i (
        .clk          (clk),
        .rstn         (rstn),
        .i_start      (refill_start),
        .i_beats      (o_mem_req.beats),
        .i_beat_valid (i_mem_beat_valid),
        .o_slot       (slot),
        .o_done       (burst_done)
    );

    icache_tagv tagv_i (
        .clk          (clk),
        .rstn         (rstn),
        .i_lookup_en  (lookup_en),
        .i_addr       (i_req.addr),   // read in the accept cycle
        .i_fill_we    (fill_we),
        .i_fill_way   (fill_way),
        .i_inval_we   (inval_we),
        .i_inval_way  (inval_way),
        .i_lru_update (lru_update),
        .i_lru_way    (lru_way),
        .o_hit        (hit),
        .o_hit_way    (hit_way),
        .o_victim_way (victim_way)
    );

    icache_data data_i (
        .clk          (clk),
        .i_lookup_en  (lookup_en),
        .i_index      (i_req.addr.fetch.index),
        .i_word       (req_buf.addr.fetch.word),
        .i_slot       (slot),
        .i_beat_valid (i_mem_beat_valid),
        .i_rdata      (i_mem_rdata),
        .i_fill_we    (fill_we),
        .i_fill_way   (fill_way),
        .i_hit_way    (hit_way),
        .i_from_buf   (from_buf),
        .i_uncached   (req_buf.uncached),
        .o_word       (word)
    );

    assign is_fetch = (req_buf.op == OP_FETCH);

    assign o_resp.data       = word;
    assign o_resp.addr_err   = addr_err;
    assign o_resp.cacop_done = !is_fetch;
    assign o_resp.hit        = is_fetch && !addr_err && !from_buf;
    assign o_resp.uncached   = is_fetch && !addr_err && req_buf.uncached;

endmodule

//--- verilog/icache_ctrl.sv
module icache_ctrl import icache_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  logic     i_req_valid,
    input  req_t     i_req,
    input  logic     i_hit,
    input  logic     i_hit_way,
    input  logic     i_victim_way,
    input  logic     i_burst_done,
    input  logic     i_mem_beat_valid,
    output logic     o_req_ready,
    output logic     o_resp_valid,
    output logic     o_lookup_en,
    output logic     o_refill_start,
    output logic     o_mem_req_valid,
    output mem_req_t o_mem_req,
    output logic     o_fill_we,
    output logic     o_fill_way,
    output logic     o_inval_we,
    output logic     o_inval_way,
    output logic     o_lru_update,
    output logic     o_lru_way,
    output logic     o_from_buf,
    output req_t     o_req_buf,
    output logic     o_addr_err
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_MISS,
        S_REFILL,
        S_RESPOND,
        S_CACOP
    } state_t;

    state_t state_q, state_d;
    req_t   req_buf;
    logic   addr_err_q;
    logic   from_buf_q;
    logic   fill_way_q;
    logic   accept;
    logic   misaligned;
    logic   go_miss;

    assign accept     = i_req_valid && o_req_ready;
    assign misaligned = (i_req.op == OP_FETCH) && (i_req.addr.fetch.byte_off != 2'b00);
    // uncached fetches and cached misses both go to memory
    assign go_miss    = (state_q == S_LOOKUP) && (req_buf.op == OP_FETCH) &&
                        (req_buf.uncached || !i_hit);

    always_ff @(posedge clk) begin
        if (!rstn)
            state_q <= S_IDLE;
        else
            state_q <= state_d;
    end

    always_ff @(posedge clk) begin
        if (accept)
            req_buf <= i_req;
        if (go_miss)
            fill_way_q <= i_victim_way;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            addr_err_q <= 1'b0;
            from_buf_q <= 1'b0;
        end else if (accept) begin
            addr_err_q <= misaligned;
            from_buf_q <= 1'b0;
        end else if (go_miss) begin
            from_buf_q <= 1'b1;   // answer comes from the line buffer
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (accept) begin
                    if (misaligned)
                        state_d = S_RESPOND;
                    else if (i_req.op == OP_IDX_INV)
                        state_d = S_CACOP;
                    else
                        state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (req_buf.op == OP_HIT_INV)
                    state_d = S_CACOP;
                else if (go_miss)
                    state_d = S_MISS;
                else
                    state_d = S_RESPOND;
            end
            S_MISS: begin
                if (i_mem_beat_valid)
                    state_d = i_burst_done ? S_RESPOND : S_REFILL;
            end
            S_REFILL: begin
                if (i_burst_done)
                    state_d = S_RESPOND;
            end
            S_RESPOND: state_d = S_IDLE;
            S_CACOP:   state_d = S_IDLE;
            default:   state_d = S_IDLE;
        endcase
    end

    assign o_req_ready     = (state_q == S_IDLE);
    assign o_resp_valid    = (state_q == S_RESPOND) || (state_q == S_CACOP);
    assign o_lookup_en     = accept && !misaligned &&
                             !((i_req.op == OP_FETCH) && i_req.uncached);
    assign o_refill_start  = go_miss;
    assign o_mem_req_valid = (state_q == S_MISS);

    // uncached reads one word, a miss reads the aligned line
    assign o_mem_req.addr  = req_buf.uncached ?
                             {req_buf.addr[31:2], 2'b00} :
                             {req_buf.addr[31:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}};
    assign o_mem_req.beats = req_buf.uncached ? 3'(BURST_UNCACHED) : 3'(BURST_LINE);

    // fill once the whole line is buffered
    assign o_fill_we  = (state_q == S_RESPOND) && from_buf_q && !req_buf.uncached;
    assign o_fill_way = fill_way_q;

    assign o_inval_we  = (state_q == S_CACOP) && ((req_buf.op == OP_IDX_INV) || i_hit);
    assign o_inval_way = (req_buf.op == OP_IDX_INV) ? req_buf.addr.cacop.way : i_hit_way;

    assign o_lru_update = o_fill_we ||
                          ((state_q == S_LOOKUP) && (req_buf.op == OP_FETCH) &&
                           !req_buf.uncached && i_hit);
    assign o_lru_way    = (state_q == S_RESPOND) ? fill_way_q : i_hit_way;

    assign o_from_buf = from_buf_q;
    assign o_req_buf  = req_buf;
    assign o_addr_err = addr_err_q;

    // request held steady until memory starts the burst
    a_mem_req_stable: assert property (@(posedge clk) disable iff (!rstn)
        o_mem_req_valid && !i_mem_beat_valid |=> o_mem_req_valid && $stable(o_mem_req));

    a_resp_single: assert property (@(posedge clk) disable iff (!rstn)
        o_resp_valid |=> !o_resp_valid);

endmodule

//--- verilog/icache_data.sv
module icache_data import icache_pkg::*; (
    input  logic                  clk,
    input  logic                  i_lookup_en,
    input  logic [INDEX_W-1:0]    i_index,
    input  logic [WORD_OFF_W-1:0] i_word,
    input  logic [WORD_OFF_W-1:0] i_slot,
    input  logic                  i_beat_valid,
    input  logic [31:0]           i_rdata,
    input  logic                  i_fill_we,
    input  logic                  i_fill_way,
    input  logic                  i_hit_way,
    input  logic                  i_from_buf,
    input  logic                  i_uncached,
    output logic [31:0]           o_word
);

    logic [LINE_WORDS-1:0][31:0] line_mem [2][SET_NUM];
    logic [LINE_WORDS-1:0][31:0] rd_line  [2];
    logic [LINE_WORDS-1:0][31:0] line_buf;    // refill line buffer
    logic [INDEX_W-1:0]          idx_q;

    // read both ways, keep index for a later fill
    always_ff @(posedge clk) begin
        if (i_lookup_en) begin
            rd_line[0] <= line_mem[0][i_index];
            rd_line[1] <= line_mem[1][i_index];
            idx_q      <= i_index;
        end
    end

    // beats land at their word slot
    always_ff @(posedge clk) begin
        if (i_beat_valid)
            line_buf[i_slot] <= i_rdata;
    end

    always_ff @(posedge clk) begin
        if (i_fill_we)
            line_mem[i_fill_way][idx_q] <= line_buf;   // whole line at once
    end

    always_comb begin
        if (!i_from_buf)
            o_word = rd_line[i_hit_way][i_word];
        else if (i_uncached)
            o_word = line_buf[0];   // single beat lands in slot 0
        else
            o_word = line_buf[i_word];
    end

endmodule

//--- verilog/icache_tagv.sv
module icache_tagv import icache_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        i_lookup_en,
    input  cache_addr_u i_addr,
    input  logic        i_fill_we,
    input  logic        i_fill_way,
    input  logic        i_inval_we,
    input  logic        i_inval_way,
    input  logic        i_lru_update,
    input  logic        i_lru_way,
    output logic        o_hit,
    output logic        o_hit_way,
    output logic        o_victim_way
);

    logic [TAG_W-1:0]         tag_mem [2][SET_NUM];
    logic [1:0][SET_NUM-1:0]  valid_q;
    logic [SET_NUM-1:0]       lru_q;    // way to replace next

    // registered read of both ways
    logic [1:0]               rd_valid;
    logic [TAG_W-1:0]         rd_tag [2];
    logic [TAG_W-1:0]         tag_q;
    logic [INDEX_W-1:0]       idx_q;
    logic [1:0]               hit_w;

    always_ff @(posedge clk) begin
        if (i_lookup_en) begin
            rd_tag[0] <= tag_mem[0][i_addr.fetch.index];
            rd_tag[1] <= tag_mem[1][i_addr.fetch.index];
            tag_q     <= i_addr.fetch.tag;
            idx_q     <= i_addr.fetch.index;
        end
        if (i_fill_we)
            tag_mem[i_fill_way][idx_q] <= tag_q;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_valid <= '0;
        end else if (i_lookup_en) begin
            rd_valid[0] <= valid_q[0][i_addr.fetch.index];
            rd_valid[1] <= valid_q[1][i_addr.fetch.index];
        end
    end

    // valid bits, all lines empty after reset
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else begin
            if (i_fill_we)
                valid_q[i_fill_way][idx_q] <= 1'b1;
            if (i_inval_we)
                valid_q[i_inval_way][idx_q] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn)
            lru_q <= '0;
        else if (i_lru_update)
            lru_q[idx_q] <= ~i_lru_way;   // the other way goes next
    end

    assign hit_w[0] = rd_valid[0] && (rd_tag[0] == tag_q);
    assign hit_w[1] = rd_valid[1] && (rd_tag[1] == tag_q);

    assign o_hit        = |hit_w;
    assign o_hit_way    = hit_w[1];
    assign o_victim_way = lru_q[idx_q];

    // a line is never filled twice into one set
    a_single_hit: assert property (@(posedge clk) disable iff (!rstn)
        !(hit_w[0] && hit_w[1]));

endmodule

//--- verilog/refill_counter.sv
module refill_counter import icache_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_start,
    input  logic [2:0]            i_beats,
    input  logic                  i_beat_valid,
    output logic [WORD_OFF_W-1:0] o_slot,
    output logic                  o_done
);

    logic [2:0] cnt;
    logic [2:0] beats_q;
    logic       armed;    // a burst is outstanding

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cnt     <= '0;
            beats_q <= '0;
            armed   <= 1'b0;
        end else if (i_start) begin
            cnt     <= '0;
            beats_q <= i_beats;
            armed   <= 1'b1;
        end else if (armed && i_beat_valid) begin
            cnt <= cnt + 3'd1;
            if (o_done)
                armed <= 1'b0;   // last beat closes the burst
        end
    end

    assign o_slot = cnt[WORD_OFF_W-1:0];
    assign o_done = armed && i_beat_valid && (cnt == beats_q - 3'd1);

    // memory must not send beats outside a requested burst
    a_no_stray_beat: assert property (@(posedge clk) disable iff (!rstn)
        i_beat_valid |-> armed);

endmodule

//--- verilog/icache_pkg.sv
package icache_pkg;

    // geometry
    localparam int INDEX_W    = 4;
    localparam int SET_NUM    = 16;
    localparam int WORD_OFF_W = 2;
    localparam int LINE_WORDS = 4;
    localparam int BYTE_OFF_W = 4;   // byte offset inside a line
    localparam int TAG_W      = 24;

    // burst lengths on the memory port
    localparam int BURST_LINE     = 4;
    localparam int BURST_UNCACHED = 1;

    typedef enum logic [1:0] {
        OP_FETCH   = 2'd0,
        OP_IDX_INV = 2'd1,
        OP_HIT_INV = 2'd2
    } op_t;

    // normal fetch view of the address
    typedef struct packed {
        logic [TAG_W-1:0]      tag;
        logic [INDEX_W-1:0]    index;
        logic [WORD_OFF_W-1:0] word;
        logic [1:0]            byte_off;
    } fetch_addr_t;

    // index-invalidate view, the way sits in bit 0
    typedef struct packed {
        logic [TAG_W-1:0]   unused_hi;
        logic [INDEX_W-1:0] index;
        logic [2:0]         unused_lo;
        logic               way;
    } cacop_addr_t;

    typedef union packed {
        fetch_addr_t fetch;
        cacop_addr_t cacop;
    } cache_addr_u;

    typedef struct packed {
        op_t         op;
        cache_addr_u addr;
        logic        uncached;
    } req_t;

    typedef struct packed {
        logic [31:0] data;
        logic        addr_err;
        logic        cacop_done;
        logic        hit;        // served without memory
        logic        uncached;
    } resp_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  beats;
    } mem_req_t;

endpackage
